/* eeprom_ctrl_top.f */
eeprom_pkg.sv
i2c_byte_shifter.sv
eeprom_sequencer.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_ctrl.sv

/* eeprom_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4   // clocks per half scl period
)(
    input  wire              CLK,
    input  wire              RESET,
    input  wire              wr,
    input  wire              rd,
    input  wire [ADDR_W-1:0] addr,
    input  wire [7:0]        wdata,
    output wire [7:0]        rdata,
    output wire              ack,
    output wire              nack_err,
    output wire              scl,
    inout  wire              sda
);

    wire [1:0] cmd;
    wire [7:0] tx_byte;
    wire       cmd_req;
    wire       cmd_ack;
    wire [7:0] rx_byte;
    wire       nacked;

    eeprom_sequencer i_seq (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .ack      (ack),
        .nack_err (nack_err),
        .cmd      (cmd),
        .tx_byte  (tx_byte),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .rx_byte  (rx_byte),
        .nacked   (nacked)
    );

    i2c_byte_shifter #(
        .CLK_DIV (CLK_DIV)
    ) i_shifter (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd),
        .tx_byte (tx_byte),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .rx_byte (rx_byte),
        .nacked  (nacked),
        .scl     (scl),
        .sda     (sda)      // pull-up lives outside
    );

endmodule

`default_nettype wire

/* eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // 24C16 array, 2 KiB
    localparam int ADDR_W = 11;

    // fixed device type code, upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef union packed {
        struct packed {
            logic [3:0] dev;
            logic [2:0] block;  // addr[10:8]
            logic       rnw;    // 1 = read
        } f;
        logic [7:0] raw;        // as it goes on the wire
    } ctrl_byte_u;

    // sequencer to shifter commands
    localparam logic [1:0] CMD_START = 2'd0;  // also used as repeated start
    localparam logic [1:0] CMD_STOP  = 2'd1;
    localparam logic [1:0] CMD_WRITE = 2'd2;  // byte out, ack sampled
    localparam logic [1:0] CMD_READ  = 2'd3;  // byte in, nack sent

endpackage

`default_nettype wire

/* eeprom_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  wire               CLK,
    input  wire               RESET,
    input  wire               wr,
    input  wire               rd,
    input  wire  [ADDR_W-1:0] addr,
    input  wire  [7:0]        wdata,
    output logic [7:0]        rdata,
    output logic              ack,
    output logic              nack_err,
    output logic [1:0]        cmd,
    output logic [7:0]        tx_byte,
    output logic              cmd_req,
    input  wire               cmd_ack,
    input  wire  [7:0]        rx_byte,
    input  wire               nacked
);

    // one-hot transaction states
    localparam logic [9:0] ST_IDLE   = 10'b00_0000_0001;
    localparam logic [9:0] ST_START  = 10'b00_0000_0010;
    localparam logic [9:0] ST_CTRL_W = 10'b00_0000_0100;
    localparam logic [9:0] ST_ADDR   = 10'b00_0000_1000;
    localparam logic [9:0] ST_DATA_W = 10'b00_0001_0000;
    localparam logic [9:0] ST_RSTART = 10'b00_0010_0000;
    localparam logic [9:0] ST_CTRL_R = 10'b00_0100_0000;
    localparam logic [9:0] ST_DATA_R = 10'b00_1000_0000;
    localparam logic [9:0] ST_STOP   = 10'b01_0000_0000;
    localparam logic [9:0] ST_DONE   = 10'b10_0000_0000;

    logic [9:0]  state;
    logic [9:0]  next_state;
    logic [1:0]  next_cmd;
    logic [7:0]  next_tx;
    logic        is_read;     // latched at request
    logic        cmd_done;
    logic        issue;
    logic        write_nacked;
    ctrl_byte_u  ctrl;

    always_comb
    begin
        ctrl.f.dev   = DEVICE_CODE;
        ctrl.f.block = addr[ADDR_W-1:8];
        ctrl.f.rnw   = (state == ST_CTRL_R);  // only after the repeated start
    end

    assign issue        = !cmd_req && !cmd_ack && state != ST_IDLE && state != ST_DONE;
    assign cmd_done     = cmd_req && cmd_ack;
    assign write_nacked = cmd_done && cmd == CMD_WRITE && nacked;

    // command for the current state and where to go after it
    always_comb
    begin
        next_cmd   = CMD_WRITE;
        next_tx    = ctrl.raw;
        next_state = ST_STOP;
        case (state)
            ST_START:
            begin
                next_cmd   = CMD_START;
                next_state = ST_CTRL_W;
            end
            ST_CTRL_W: next_state = nacked ? ST_STOP : ST_ADDR;
            ST_ADDR:
            begin
                next_tx = addr[7:0];
                if (nacked)
                    next_state = ST_STOP;
                else
                    next_state = is_read ? ST_RSTART : ST_DATA_W;
            end
            ST_DATA_W: next_tx = wdata;
            ST_RSTART:
            begin
                next_cmd   = CMD_START;
                next_state = ST_CTRL_R;
            end
            ST_CTRL_R: next_state = nacked ? ST_STOP : ST_DATA_R;
            ST_DATA_R: next_cmd = CMD_READ;
            ST_STOP:
            begin
                next_cmd   = CMD_STOP;
                next_state = ST_DONE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            is_read  <= 1'b0;
            cmd_req  <= 1'b0;
            ack      <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (wr || rd)
                    begin
                        is_read  <= !wr;  // wr wins
                        nack_err <= 1'b0;
                        state    <= ST_START;
                    end
                end
                ST_DONE:
                begin
                    // hold ack until the host lets go
                    if (!(wr || rd))
                    begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    if (issue)
                    begin
                        cmd_req <= 1'b1;
                    end
                    else if (cmd_done)
                    begin
                        cmd_req <= 1'b0;
                        state   <= next_state;
                        if (write_nacked)
                            nack_err <= 1'b1;
                        if (state == ST_STOP)
                            ack <= 1'b1;
                    end
                end
            endcase
        end
    end

    // payload toward the shifter and the host
    always_ff @(posedge CLK)
    begin
        if (issue)
        begin
            cmd     <= next_cmd;
            tx_byte <= next_tx;
        end
        if (cmd_done && state == ST_DATA_R)
            rdata <= rx_byte;
    end

endmodule

`default_nettype wire

/* i2c_byte_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_shifter
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)(
    input  wire        CLK,
    input  wire        RESET,
    input  wire  [1:0] cmd,
    input  wire  [7:0] tx_byte,
    input  wire        cmd_req,
    output logic       cmd_ack,
    output logic [7:0] rx_byte,
    output logic       nacked,
    output wire        scl,
    inout  wire        sda
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]       state;
    logic [1:0]       cur_cmd;
    logic [7:0]       tx_q;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       half_cnt;   // two halves per bit
    logic [4:0]       last_half;
    logic             half_end;
    logic             high_half;
    logic [3:0]       bit_idx;
    logic             scl_q;
    logic             sda_low;    // open-drain pull enable

    // {scl, sda_low} for a given half of a command
    function automatic logic [1:0] half_drive(
        input logic [1:0] c,
        input logic [4:0] h,
        input logic [7:0] b
    );
        logic [3:0] bi;
        logic [1:0] d;
        bi = h[4:1];
        case (c)
            CMD_START: d = {1'b1, h[0]};     // scl high, then sda falls
            CMD_STOP:  d = {h[0], 1'b1};     // sda low, then scl rises
            CMD_WRITE: d = {h[0], (bi < 4'd8) ? ~b[3'(7 - bi)] : 1'b0};
            default:   d = {h[0], 1'b0};     // read and its nack leave sda released
        endcase
        return d;
    endfunction

    assign half_end  = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign high_half = half_cnt[0];
    assign bit_idx   = half_cnt[4:1];
    assign last_half = (cur_cmd == CMD_WRITE || cur_cmd == CMD_READ) ? 5'd17 : 5'd1;

    assign scl = scl_q;
    assign sda = sda_low ? 1'b0 : 1'bz;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= ST_IDLE;
            cur_cmd  <= CMD_STOP;
            div_cnt  <= '0;
            half_cnt <= '0;
            cmd_ack  <= 1'b0;
            nacked   <= 1'b0;
            scl_q    <= 1'b1;   // bus idle
            sda_low  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_req)
                    begin
                        cur_cmd  <= cmd;
                        div_cnt  <= '0;
                        half_cnt <= '0;
                        {scl_q, sda_low} <= half_drive(cmd, 5'd0, tx_byte);
                        state    <= ST_RUN;
                    end
                end
                ST_RUN:
                begin
                    if (half_end)
                    begin
                        div_cnt <= '0;
                        if (high_half && cur_cmd == CMD_WRITE && bit_idx == 4'd8)
                            nacked <= sda;  // ack slot
                        if (half_cnt == last_half)
                        begin
                            // park: scl low between bytes, stop releases sda
                            scl_q   <= (cur_cmd == CMD_STOP);
                            sda_low <= (cur_cmd == CMD_START);
                            cmd_ack <= 1'b1;
                            state   <= ST_DONE;
                        end
                        else
                        begin
                            half_cnt <= half_cnt + 5'd1;
                            {scl_q, sda_low} <= half_drive(cur_cmd, half_cnt + 5'd1, tx_q);
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                ST_DONE:
                begin
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // payload
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && cmd_req)
            tx_q <= tx_byte;
        if (state == ST_RUN && half_end && high_half && cur_cmd == CMD_READ
                && bit_idx < 4'd8)
            rx_byte <= {rx_byte[6:0], sda};   // msb first
    end

endmodule

`default_nettype wire

/* tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int TIMEOUT  = 5000;
    localparam int MEM_SIZE = 2 ** ADDR_W;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    wire  [7:0]        rdata;
    wire               ack;
    wire               nack_err;
    wire               scl;
    wire               sda;
    logic              ack_en;      // model answers its address
    logic              ack_q;
    logic              req_wr;      // request as last held by the host
    logic [ADDR_W-1:0] req_addr;
    logic [7:0]        req_data;
    logic [7:0]        shadow [0:MEM_SIZE-1];
    logic              written [0:MEM_SIZE-1];
    logic [ADDR_W-1:0] a;
    logic [7:0]        d;
    int                i;
    int                mark;
    int                errors;
    int                checks;
    int                first_draw;

    eeprom_ctrl_top #(.CLK_DIV(4)) i_dut (.*);
    tb_eeprom_model i_model (.scl(scl), .sda(sda), .ack_en(ack_en));
    pullup (sda);

    always #5 CLK = ~CLK;

    function automatic logic [7:0] preload_val(input logic [ADDR_W-1:0] adr);
        return adr[7:0] ^ 8'h5a;
    endfunction

    // what a read of this address must return
    function automatic logic [7:0] expected_byte(input logic [ADDR_W-1:0] adr);
        return written[adr] ? shadow[adr] : preload_val(adr);
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("stuck at %0t: %s within %0d cycles", $time, what, TIMEOUT);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (ack !== level && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (ack !== level)
            abort_run(what);
    endtask

    // one four-phase host transfer, request held hold extra cycles after ack
    task automatic host_xfer(input logic do_wr, input logic do_rd, input logic [ADDR_W-1:0] adr,
                             input logic [7:0] dat, input int hold);
        @(negedge CLK);
        wr    = do_wr;
        rd    = do_rd;
        addr  = adr;
        wdata = dat;
        wait_ack(1'b1, "ack did not rise");
        repeat (hold)
        begin
            @(negedge CLK);
            check_flag("ack", ack, 1'b1);
        end
        wr = 1'b0;
        rd = 1'b0;
        @(negedge CLK);
        check_flag("ack", ack, 1'b0);   // one cycle after the request drops
        wait_ack(1'b0, "ack did not fall");
    endtask

    task automatic close_test(input string name);
        $display("test %s: %0d errors", name, errors - mark);
    endtask

    // request captured while the host holds it
    always @(posedge CLK)
    begin
        if (wr || rd)
        begin
            req_wr   <= wr;     // wr wins over rd
            req_addr <= addr;
            req_data <= wdata;
        end
    end

    // checks each finished transfer as ack rises
    always @(negedge CLK)
    begin
        ack_q <= ack;
        if (ack === 1'b1 && ack_q === 1'b0)
        begin
            check_flag("scl", scl, 1'b1);   // stop left the bus idle
            check_flag("sda", sda, 1'b1);
            check_flag("nack_err", nack_err, !ack_en);
            if (req_wr && ack_en)
            begin
                shadow[req_addr]  = req_data;
                written[req_addr] = 1'b1;
            end
            else if (!req_wr && ack_en)
                check_byte("rdata", rdata, expected_byte(req_addr));
        end
    end

    initial
    begin
        first_draw = $urandom(32'h9af3_f564);
        CLK    = 1'b0;
        RESET  = 1'b1;
        wr     = 1'b0;
        rd     = 1'b0;
        addr   = '0;
        wdata  = '0;
        ack_en = 1'b1;
        errors = 0;
        checks = 0;
        for (i = 0; i < MEM_SIZE; i++)
        begin
            written[i]      = 1'b0;
            i_model.mem[i]  = preload_val(i);
        end
        repeat (10) @(negedge CLK);
        RESET = 1'b0;

        mark = errors;
        @(negedge CLK);
        check_flag("ack", ack, 1'b0);
        check_flag("nack_err", nack_err, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda", sda, 1'b1);
        close_test("reset state");

        mark = errors;
        repeat (8)
        begin
            a = $urandom_range(MEM_SIZE - 1);
            host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        end
        close_test("preloaded reads");

        mark = errors;
        repeat (6)
        begin
            a = $urandom_range(MEM_SIZE - 1);
            d = $urandom_range(255);
            host_xfer(1'b1, 1'b0, a, d, 0);
            host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        end
        a = $urandom_range(MEM_SIZE - 1);
        for (i = 0; i < 8; i++)     // same low byte in every block
        begin
            a = {i[2:0], a[7:0]};
            d = $urandom_range(255);
            host_xfer(1'b1, 1'b0, a, d, 0);
        end
        for (i = 0; i < 8; i++)
        begin
            a = {i[2:0], a[7:0]};
            host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        end
        close_test("write and read back");

        mark = errors;
        a = $urandom_range(MEM_SIZE - 1);
        d = $urandom_range(255);
        host_xfer(1'b1, 1'b0, a, d, $urandom_range(20, 1));
        host_xfer(1'b0, 1'b1, a, 8'h00, $urandom_range(20, 1));
        host_xfer(1'b1, 1'b1, a, ~expected_byte(a), 3);
        host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        close_test("four-phase handshake");

        mark = errors;
        a = $urandom_range(MEM_SIZE - 1);
        ack_en = 1'b0;
        host_xfer(1'b1, 1'b0, a, ~expected_byte(a), 0);
        ack_en = 1'b1;
        host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        close_test("missing device ack");

        mark = errors;
        ack_en = 1'b0;
        host_xfer(1'b0, 1'b1, a, 8'h00, 0);     // aborted read
        ack_en = 1'b1;
        d = $urandom_range(255);
        host_xfer(1'b1, 1'b0, a, d, 0);
        host_xfer(1'b0, 1'b1, a, 8'h00, 0);
        close_test("bus idle after transfers");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_eeprom_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_model (
    input  wire scl,
    inout  wire sda,
    input  wire ack_en      // low: device never acknowledges
);

    logic [7:0]  mem [0:2047];
    logic [7:0]  shreg;
    logic [3:0]  bit_cnt;   // 9 while in the ack slot
    logic [1:0]  byte_no;
    logic [2:0]  block;
    logic [10:0] ptr;
    logic [7:0]  wr_data;
    logic        rx_mode;
    logic        tx_mode;
    logic        acked;
    logic        wr_pend;   // committed on stop
    logic        sda_low;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        rx_mode = 1'b0;
        tx_mode = 1'b0;
        wr_pend = 1'b0;
        sda_low = 1'b0;
    end

    // start or stop, looked at just after the edge so a falling scl is not mistaken
    always @(sda)
    begin
        #1;
        if (scl === 1'b1 && sda === 1'b0)
        begin
            rx_mode = 1'b1;
            tx_mode = 1'b0;
            wr_pend = 1'b0;
            bit_cnt = 4'd0;
            byte_no = 2'd0;
        end
        else if (scl === 1'b1 && sda === 1'b1)
        begin
            if (wr_pend)
                mem[ptr] = wr_data;
            wr_pend = 1'b0;
            rx_mode = 1'b0;
            tx_mode = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (tx_mode && bit_cnt == 4'd8)
            tx_mode = 1'b0;     // controller's ack slot, single byte reads
        else if (tx_mode)
        begin
            shreg   = {shreg[6:0], 1'b0};
            bit_cnt = bit_cnt + 4'd1;
        end
        else if (rx_mode && bit_cnt < 4'd8)
        begin
            shreg   = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (tx_mode)
            sda_low = (bit_cnt < 4'd8) && !shreg[7];
        else if (rx_mode && bit_cnt == 4'd8)
        begin
            acked = ack_en;
            case (byte_no)
                2'd0:
                begin
                    acked = ack_en && shreg[7:4] == 4'b1010;
                    if (!shreg[0])
                        block = shreg[3:1];
                end
                2'd1: ptr = {block, shreg};
                2'd2:
                begin
                    wr_data = shreg;
                    wr_pend = acked;
                end
                default: acked = 1'b0;  // no page writes
            endcase
            bit_cnt = 4'd9;
            sda_low = acked;
        end
        else if (rx_mode && bit_cnt == 4'd9)
        begin
            bit_cnt = 4'd0;
            sda_low = 1'b0;
            if (!acked)
                rx_mode = 1'b0;         // wait for the next start
            else if (byte_no == 2'd0 && shreg[0])
            begin
                rx_mode = 1'b0;
                tx_mode = 1'b1;
                shreg   = mem[ptr];
                sda_low = !shreg[7];    // msb out right away
            end
            else
                byte_no = byte_no + 2'd1;
        end
    end

endmodule

`default_nettype wire
